/* compile.f */
common/resp_bank_cfg_pkg.sv
common/resp_bank_cell_pkg.sv
source/free_addr_alloc.sv
linked_list/list_pointers.sv
source/release_arbiter.sv
source/payload_store.sv
source/resp_bank_top.sv
verification/resp_bank_assertions.sv
verification/tb_resp_bank.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; passes only on the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_resp_bank -o tb_resp_bank \
  && ./obj_dir/tb_resp_bank +verilator+error+limit+1000 | tee /dev/stderr \
     | grep -q "TESTS PASSED" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

/* verification/tb_resp_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_resp_bank
  import resp_bank_cfg_pkg::*;
();

  localparam int unsigned Seed = 32'hf7d64755;
  localparam int NumRandomOps = 400;
  localparam int NumOps = 2 * Capacity + 20 + NumRandomOps;
  // Every operation gets a generous budget of cycles
  localparam int TimeoutCycles = NumOps * 20;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  id_mask_t   i_rsv_id_onehot;
  logic       i_rsv_valid;
  logic       o_rsv_ready;
  addr_t      o_rsv_addr;
  id_t        i_rsp_id;
  payload_t   i_rsp_payload;
  logic       i_in_valid;
  logic       o_in_ready;
  cell_mask_t i_release_en;
  cell_mask_t o_released_onehot;
  logic       o_out_valid;
  logic       i_out_ready;
  id_t        o_rsp_id;
  payload_t   o_rsp_payload;

  // Reference model, one queue of reserved cells per identifier in reservation order
  addr_t      rsv_q [NumIds][$];
  // Number of filled cells at the front of each queue
  int         fill_idx [NumIds] = '{default: 0};
  payload_t   cell_payload [Capacity];
  cell_mask_t free_mask = '1;
  cell_mask_t filled_mask = '0;
  // Filled cells that have seen their release bit at least once
  cell_mask_t seen_en = '0;
  int         unfilled_count = 0;

  // Output as seen in the previous cycle, for the hold rule
  logic prev_valid = 1'b0;
  logic prev_fire = 1'b0;
  id_t  prev_id = '0;

  int    errors = 0;
  int    checks = 0;
  int    test_errors = 0;
  int    cycle_count = 0;
  string test_name = "reset";

  always #5 clk_i = ~clk_i;

  resp_bank_top dut0 (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .i_rsv_id_onehot   (i_rsv_id_onehot),
    .i_rsv_valid       (i_rsv_valid),
    .o_rsv_ready       (o_rsv_ready),
    .o_rsv_addr        (o_rsv_addr),
    .i_rsp_id          (i_rsp_id),
    .i_rsp_payload     (i_rsp_payload),
    .i_in_valid        (i_in_valid),
    .o_in_ready        (o_in_ready),
    .i_release_en      (i_release_en),
    .o_released_onehot (o_released_onehot),
    .o_out_valid       (o_out_valid),
    .i_out_ready       (i_out_ready),
    .o_rsp_id          (o_rsp_id),
    .o_rsp_payload     (o_rsp_payload)
  );

  bind resp_bank_top resp_bank_assertions u_assertions (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .i_in_valid        (i_in_valid),
    .i_in_ready        (o_in_ready),
    .i_out_valid       (o_out_valid),
    .i_out_ready       (i_out_ready),
    .i_released_onehot (o_released_onehot)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference rules and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  // The bank always hands out the lowest free address
  function automatic addr_t ref_lowest_free(cell_mask_t mask);
    addr_t lowest;
    logic  found;
    lowest = '0;
    found  = 1'b0;
    for (int i = 0; i < Capacity; i++) begin
      if (mask[i] && !found) begin
        lowest = addr_t'(i);
        found  = 1'b1;
      end
    end
    return lowest;
  endfunction

  function automatic id_t onehot_to_id(id_mask_t onehot);
    id_t id;
    id = '0;
    for (int k = 0; k < NumIds; k++) begin
      if (onehot[k]) begin
        id = id_t'(k);
      end
    end
    return id;
  endfunction

  task automatic report_failure(input string msg);
    errors++;
    $display("Error in %s: %s", test_name, msg);
  endtask

  task automatic addr_check(input string what, input addr_t exp, input addr_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Mismatch in %s: %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic id_check(input string what, input id_t exp, input id_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Mismatch in %s: %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic payload_check(input string what, input payload_t exp, input payload_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Mismatch in %s: %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic mask_check(input string what, input cell_mask_t exp, input cell_mask_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Mismatch in %s: %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic flag_check(input string what, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Mismatch in %s: %s expected %b actual %b", test_name, what, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////////////////////////////////////////

  // Inputs change on the rising edge, so the falling edge sees the values
  // that the next rising edge will act on
  always @(negedge clk_i) begin : compare_outputs
    logic       exp_rsv;
    logic       exp_in;
    logic       front_ok;
    logic       out_fire;
    addr_t      low_addr;
    addr_t      front_addr;
    addr_t      fill_addr;
    id_t        rsv_id;
    cell_mask_t exp_released;
    if (rst_ni) begin
      exp_rsv  = free_mask != '0;
      low_addr = ref_lowest_free(free_mask);
      flag_check("o_rsv_ready", exp_rsv, o_rsv_ready);
      if (exp_rsv) begin
        addr_check("o_rsv_addr", low_addr, o_rsv_addr);
      end
      exp_in = i_in_valid && (fill_idx[i_rsp_id] < rsv_q[i_rsp_id].size());
      flag_check("o_in_ready", exp_in, o_in_ready);

      // The offered cell must be the oldest filled one of its identifier
      front_ok   = 1'b0;
      front_addr = '0;
      if (o_out_valid) begin
        front_ok = fill_idx[o_rsp_id] > 0;
        if (!front_ok) begin
          report_failure($sformatf("output for identifier %0d with no filled cell", o_rsp_id));
        end else begin
          front_addr = rsv_q[o_rsp_id][0];
          payload_check("o_rsp_payload", cell_payload[front_addr], o_rsp_payload);
          if (!seen_en[front_addr]) begin
            report_failure($sformatf("cell %0d was output without a release enable",
                                     front_addr));
          end
        end
      end
      if (prev_valid && !prev_fire) begin
        if (!o_out_valid) begin
          report_failure("output valid dropped before its handshake");
        end else begin
          id_check("held o_rsp_id", prev_id, o_rsp_id);
        end
      end
      out_fire     = o_out_valid && i_out_ready && front_ok;
      exp_released = out_fire ? (cell_mask_t'(1) << front_addr) : '0;
      mask_check("o_released_onehot", exp_released, o_released_onehot);

      // The arbiter looks at the release bits of cells that are already filled
      seen_en = seen_en | (i_release_en & filled_mask);

      if (i_rsv_valid && exp_rsv) begin
        rsv_id = onehot_to_id(i_rsv_id_onehot);
        rsv_q[rsv_id].push_back(low_addr);
        free_mask[low_addr] = 1'b0;
        unfilled_count++;
      end
      // Fills land on the oldest reservation not yet filled
      if (exp_in) begin
        fill_addr = rsv_q[i_rsp_id][fill_idx[i_rsp_id]];
        cell_payload[fill_addr] = i_rsp_payload;
        filled_mask[fill_addr] = 1'b1;
        fill_idx[i_rsp_id]++;
        unfilled_count--;
      end
      if (out_fire) begin
        void'(rsv_q[o_rsp_id].pop_front());
        fill_idx[o_rsp_id]--;
        free_mask[front_addr]   = 1'b1;
        filled_mask[front_addr] = 1'b0;
        seen_en[front_addr]     = 1'b0;
      end
      prev_valid = o_out_valid;
      prev_fire  = o_out_valid && i_out_ready;
      prev_id    = o_rsp_id;
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = errors;
  endtask

  task automatic finish_test();
    if (errors == test_errors) begin
      $display("Test %s: ok", test_name);
    end else begin
      $display("Test %s: %0d errors", test_name, errors - test_errors);
    end
  endtask

  // Identifier NumIds-1 is left without reservations on purpose
  task automatic reserve_all();
    start_test("reserve_all");
    for (int i = 0; i <= Capacity; i++) begin
      @(posedge clk_i);
      i_rsv_valid     <= 1'b1;
      i_rsv_id_onehot <= id_mask_t'(1) << ($urandom % (NumIds - 1));
    end
    @(posedge clk_i);
    i_rsv_valid <= 1'b0;
    finish_test();
  endtask

  task automatic fill_all();
    start_test("fill_in_order");
    repeat (2) begin
      @(posedge clk_i);
      i_in_valid    <= 1'b1;
      i_rsp_id      <= id_t'(NumIds - 1);
      i_rsp_payload <= payload_t'($urandom);
    end
    while (unfilled_count != 0) begin
      @(posedge clk_i);
      i_rsp_id      <= id_t'($urandom % NumIds);
      i_rsp_payload <= payload_t'($urandom);
    end
    @(posedge clk_i);
    i_in_valid <= 1'b0;
    finish_test();
  endtask

  // All cells are filled, yet nothing may leave without a release bit
  task automatic idle_without_release();
    start_test("no_release");
    repeat (20) begin
      @(posedge clk_i);
      i_out_ready <= ($urandom % 2) != 0;
    end
    finish_test();
  endtask

  task automatic random_traffic();
    start_test("random_traffic");
    repeat (NumRandomOps) begin
      @(posedge clk_i);
      i_rsv_valid     <= ($urandom % 2) != 0;
      i_rsv_id_onehot <= id_mask_t'(1) << ($urandom % NumIds);
      i_in_valid      <= ($urandom % 2) != 0;
      i_rsp_id        <= id_t'($urandom % NumIds);
      i_rsp_payload   <= payload_t'($urandom);
      i_release_en    <= cell_mask_t'($urandom);
      i_out_ready     <= ($urandom % 4) != 0;
    end
    finish_test();
  endtask

  // Fill what is still reserved and release everything until the bank is empty
  task automatic drain_bank();
    start_test("drain");
    @(posedge clk_i);
    i_rsv_valid  <= 1'b0;
    i_release_en <= '1;
    while (free_mask != '1) begin
      @(posedge clk_i);
      i_in_valid    <= unfilled_count != 0;
      i_rsp_id      <= id_t'($urandom % NumIds);
      i_rsp_payload <= payload_t'($urandom);
      i_out_ready   <= ($urandom % 4) != 0;
    end
    @(posedge clk_i);
    i_in_valid  <= 1'b0;
    i_out_ready <= 1'b1;
    repeat (4) @(posedge clk_i);
    finish_test();
  endtask

  initial begin
    void'($urandom(Seed));
    rst_ni          <= 1'b0;
    i_rsv_id_onehot <= '0;
    i_rsv_valid     <= 1'b0;
    i_rsp_id        <= '0;
    i_rsp_payload   <= '0;
    i_in_valid      <= 1'b0;
    i_release_en    <= '0;
    i_out_ready     <= 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    reserve_all();
    fill_all();
    idle_without_release();
    random_traffic();
    drain_bank();

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/resp_bank_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module resp_bank_assertions
  import resp_bank_cfg_pkg::*;
(
  input wire logic       clk_i,
  input wire logic       rst_ni,
  input wire logic       i_in_valid,
  input wire logic       i_in_ready,
  input wire logic       i_out_valid,
  input wire logic       i_out_ready,
  input wire cell_mask_t i_released_onehot
);

  ////////////////////////////////////////////////////////////////////////////
  // Output side
  ////////////////////////////////////////////////////////////////////////////

  // Only one cell can leave the bank per cycle
  released_at_most_one: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0(i_released_onehot)
  ) else $error("More than one cell reported as released in one cycle");

  // A stalled response stays offered until the requester takes it
  out_valid_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    i_out_valid && !i_out_ready |=> i_out_valid
  ) else $error("Output valid dropped without a handshake");

  ////////////////////////////////////////////////////////////////////////////
  // Input side
  ////////////////////////////////////////////////////////////////////////////

  // Ready is derived from valid, so it is never high on its own
  in_ready_needs_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    i_in_ready |-> i_in_valid
  ) else $error("Input ready high while input valid is low");

endmodule

`default_nettype wire

/* source/resp_bank_top.sv */
`timescale 1ns/1ps
`default_nettype none

module resp_bank_top
  import resp_bank_cfg_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  // Reservation
  input  wire id_mask_t   i_rsv_id_onehot,
  input  wire logic       i_rsv_valid,
  output logic            o_rsv_ready,
  output addr_t           o_rsv_addr,
  // Response input from the real controller
  input  wire id_t        i_rsp_id,
  input  wire payload_t   i_rsp_payload,
  input  wire logic       i_in_valid,
  output logic            o_in_ready,
  // Release control
  input  wire cell_mask_t i_release_en,
  output cell_mask_t      o_released_onehot,
  // Response output to the requester
  output logic            o_out_valid,
  input  wire logic       i_out_ready,
  output id_t             o_rsp_id,
  output payload_t        o_rsp_payload
);

  logic  rsv_fire;
  addr_t free_addr;
  addr_t fill_addr;
  logic  out_fire;
  id_t   out_id;
  addr_t out_addr;
  logic  rd_en;
  addr_t rd_addr;

  addr_t oldest_addr [NumIds];
  addr_t next_oldest_addr [NumIds];
  len_t  filled_len [NumIds];

  assign rsv_fire   = i_rsv_valid && o_rsv_ready;
  assign o_rsv_addr = free_addr;
  assign o_rsp_id   = out_id;

  // Stage 1 allocates cells and tracks their state
  free_addr_alloc u_alloc (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .i_rsv_fire        (rsv_fire),
    .i_fill_fire       (o_in_ready),
    .i_fill_addr       (fill_addr),
    .i_out_fire        (out_fire),
    .i_out_addr        (out_addr),
    .o_free_addr       (free_addr),
    .o_rsv_ready       (o_rsv_ready),
    .o_released_onehot (o_released_onehot)
  );

  // Stage 2 links cells into the per-identifier lists
  list_pointers u_lists (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .i_rsv_id_onehot    (i_rsv_id_onehot),
    .i_rsv_fire         (rsv_fire),
    .i_free_addr        (free_addr),
    .i_rsp_id           (i_rsp_id),
    .i_in_valid         (i_in_valid),
    .i_out_fire         (out_fire),
    .i_out_id           (out_id),
    .o_in_ready         (o_in_ready),
    .o_fill_addr        (fill_addr),
    .o_oldest_addr      (oldest_addr),
    .o_next_oldest_addr (next_oldest_addr),
    .o_filled_len       (filled_len)
  );

  // Stage 3 selects the next released cell
  release_arbiter u_arbiter (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .i_release_en       (i_release_en),
    .i_oldest_addr      (oldest_addr),
    .i_next_oldest_addr (next_oldest_addr),
    .i_filled_len       (filled_len),
    .i_out_ready        (i_out_ready),
    .o_out_valid        (o_out_valid),
    .o_out_id           (out_id),
    .o_out_addr         (out_addr),
    .o_rd_en            (rd_en),
    .o_rd_addr          (rd_addr),
    .o_out_fire         (out_fire)
  );

  // Stage 4 holds the payloads
  payload_store u_store (
    .clk_i     (clk_i),
    .i_wr_en   (o_in_ready),
    .i_wr_addr (fill_addr),
    .i_wr_data (i_rsp_payload),
    .i_rd_en   (rd_en),
    .i_rd_addr (rd_addr),
    .o_rd_data (o_rsp_payload)
  );

endmodule

`default_nettype wire

/* source/payload_store.sv */
`timescale 1ns/1ps
`default_nettype none

module payload_store
  import resp_bank_cfg_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     i_wr_en,
  input  wire addr_t    i_wr_addr,
  input  wire payload_t i_wr_data,
  input  wire logic     i_rd_en,
  input  wire addr_t    i_rd_addr,
  output payload_t      o_rd_data
);

  payload_t mem [Capacity];
  payload_t rd_data_q;

  // Write port, driven by the response input
  always_ff @(posedge clk_i) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  // Read port with one cycle of latency
  // Data holds between reads so a stalled output keeps its payload
  always_ff @(posedge clk_i) begin
    if (i_rd_en) begin
      rd_data_q <= mem[i_rd_addr];
    end
  end

  assign o_rd_data = rd_data_q;

endmodule

`default_nettype wire

/* source/release_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module release_arbiter
  import resp_bank_cfg_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire cell_mask_t i_release_en,
  input  wire addr_t      i_oldest_addr [NumIds],
  input  wire addr_t      i_next_oldest_addr [NumIds],
  input  wire len_t       i_filled_len [NumIds],
  input  wire logic       i_out_ready,
  output logic            o_out_valid,
  output id_t             o_out_id,
  output addr_t           o_out_addr,
  output logic            o_rd_en,
  output addr_t           o_rd_addr,
  output logic            o_out_fire
);

  logic  valid_q;
  id_t   id_q;
  addr_t addr_q;

  addr_t    cand_addr [NumIds];
  len_t     len_after [NumIds];
  id_mask_t leaving;
  id_mask_t cand_ok;

  logic  sel_found;
  id_t   sel_id;
  logic  load;

  assign o_out_fire = valid_q && i_out_ready;

  // The register takes a new cell when it is empty or its cell is accepted
  assign load = !valid_q || i_out_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Candidate per identifier
  ////////////////////////////////////////////////////////////////////////////

  // When the oldest cell of a list is leaving now, the one behind it is next
  always_comb begin
    for (int k = 0; k < NumIds; k++) begin
      leaving[k]   = o_out_fire && (id_q == id_t'(k));
      len_after[k] = i_filled_len[k] - len_t'(leaving[k]);
      if (leaving[k]) begin
        cand_addr[k] = i_next_oldest_addr[k];
      end else begin
        cand_addr[k] = i_oldest_addr[k];
      end
      cand_ok[k] = (len_after[k] != '0) && i_release_en[cand_addr[k]];
    end
  end

  // Lowest identifier wins
  always_comb begin
    sel_found = 1'b0;
    sel_id    = '0;
    for (int k = NumIds - 1; k >= 0; k--) begin
      if (cand_ok[k]) begin
        sel_found = 1'b1;
        sel_id    = id_t'(k);
      end
    end
  end

  // The memory read is started with the register load so both line up
  assign o_rd_en   = load && sel_found;
  assign o_rd_addr = cand_addr[sel_id];

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      id_q    <= '0;
      addr_q  <= '0;
    end else if (load) begin
      valid_q <= sel_found;
      id_q    <= sel_id;
      addr_q  <= cand_addr[sel_id];
    end
  end

  assign o_out_valid = valid_q;
  assign o_out_id    = id_q;
  assign o_out_addr  = addr_q;

endmodule

`default_nettype wire

/* linked_list/list_pointers.sv */
`timescale 1ns/1ps
`default_nettype none

module list_pointers
  import resp_bank_cfg_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire id_mask_t i_rsv_id_onehot,
  input  wire logic     i_rsv_fire,
  input  wire addr_t    i_free_addr,
  input  wire id_t      i_rsp_id,
  input  wire logic     i_in_valid,
  input  wire logic     i_out_fire,
  input  wire id_t      i_out_id,
  output logic          o_in_ready,
  output addr_t         o_fill_addr,
  output addr_t         o_oldest_addr [NumIds],
  output addr_t         o_next_oldest_addr [NumIds],
  output len_t          o_filled_len [NumIds]
);

  // Each list runs oldest filled cell, other filled cells, fill pointer,
  // other reserved cells, reservation tail
  addr_t rsv_tail_q [NumIds];
  addr_t rsv_tail_d [NumIds];
  addr_t fill_ptr_q [NumIds];
  addr_t fill_ptr_d [NumIds];
  addr_t oldest_q [NumIds];
  addr_t oldest_d [NumIds];

  // Reserved cells still waiting for a response, and cells holding one
  len_t rsv_len_q [NumIds];
  len_t rsv_len_d [NumIds];
  len_t filled_len_q [NumIds];
  len_t filled_len_d [NumIds];

  // Filled count once a cell leaving this cycle is taken away
  len_t filled_after [NumIds];

  // Next-cell links, shared by all lists
  addr_t link_q [Capacity];
  logic  link_we;
  addr_t link_waddr;

  id_mask_t rsv_hit;
  id_mask_t fill_hit;
  id_mask_t out_hit;

  // Ready depends on valid, and only for an identifier with a free reservation
  assign o_in_ready  = i_in_valid && (rsv_len_q[i_rsp_id] != '0);
  assign o_fill_addr = fill_ptr_q[i_rsp_id];

  always_comb begin
    for (int k = 0; k < NumIds; k++) begin
      rsv_hit[k]  = i_rsv_fire && i_rsv_id_onehot[k];
      fill_hit[k] = o_in_ready && (i_rsp_id == id_t'(k));
      out_hit[k]  = i_out_fire && (i_out_id == id_t'(k));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pointer and length update
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    link_we    = 1'b0;
    link_waddr = '0;
    for (int k = 0; k < NumIds; k++) begin
      rsv_tail_d[k]   = rsv_tail_q[k];
      fill_ptr_d[k]   = fill_ptr_q[k];
      oldest_d[k]     = oldest_q[k];
      filled_after[k] = filled_len_q[k] - len_t'(out_hit[k]);

      // A new cell goes behind the tail. An empty list has a stale tail that
      // may sit inside another list, so its link is left alone
      if (rsv_hit[k]) begin
        rsv_tail_d[k] = i_free_addr;
        if (rsv_len_q[k] == '0) begin
          fill_ptr_d[k] = i_free_addr;
        end
        if (rsv_len_q[k] != '0 || filled_len_q[k] != '0) begin
          link_we    = 1'b1;
          link_waddr = rsv_tail_q[k];
        end
      end

      // With one reservation left the link may be written in this very cycle,
      // so the new cell is taken straight from the allocator
      if (fill_hit[k]) begin
        if (fill_ptr_q[k] == rsv_tail_q[k]) begin
          fill_ptr_d[k] = i_free_addr;
        end else begin
          fill_ptr_d[k] = link_q[fill_ptr_q[k]];
        end
      end

      // A fill into a list with no filled cell left becomes its oldest cell
      if (fill_hit[k] && filled_after[k] == '0) begin
        oldest_d[k] = fill_ptr_q[k];
      end else if (out_hit[k]) begin
        oldest_d[k] = link_q[oldest_q[k]];
      end

      rsv_len_d[k]    = rsv_len_q[k] + len_t'(rsv_hit[k]) - len_t'(fill_hit[k]);
      filled_len_d[k] = filled_after[k] + len_t'(fill_hit[k]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsv_tail_q   <= '{default: '0};
      fill_ptr_q   <= '{default: '0};
      oldest_q     <= '{default: '0};
      rsv_len_q    <= '{default: '0};
      filled_len_q <= '{default: '0};
    end else begin
      rsv_tail_q   <= rsv_tail_d;
      fill_ptr_q   <= fill_ptr_d;
      oldest_q     <= oldest_d;
      rsv_len_q    <= rsv_len_d;
      filled_len_q <= filled_len_d;
    end
  end

  // Links are only followed inside a list's length, so stale entries are harmless
  always_ff @(posedge clk_i) begin
    if (link_we) begin
      link_q[link_waddr] <= i_free_addr;
    end
  end

  // The cell behind the oldest lets the arbiter look past a leaving cell
  always_comb begin
    for (int k = 0; k < NumIds; k++) begin
      o_oldest_addr[k]      = oldest_q[k];
      o_next_oldest_addr[k] = link_q[oldest_q[k]];
      o_filled_len[k]       = filled_len_q[k];
    end
  end

endmodule

`default_nettype wire

/* source/free_addr_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

module free_addr_alloc
  import resp_bank_cfg_pkg::*;
  import resp_bank_cell_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic       i_rsv_fire,
  input  wire logic       i_fill_fire,
  input  wire addr_t      i_fill_addr,
  input  wire logic       i_out_fire,
  input  wire addr_t      i_out_addr,
  output addr_t           o_free_addr,
  output logic            o_rsv_ready,
  output cell_mask_t      o_released_onehot
);

  cell_state_e state_q [Capacity];
  cell_state_e state_d [Capacity];

  logic  free_found;
  addr_t free_addr;

  ////////////////////////////////////////////////////////////////////////////
  // Lowest free cell
  ////////////////////////////////////////////////////////////////////////////

  // Scan from the top down so the last hit is the lowest free address
  always_comb begin
    free_found = 1'b0;
    free_addr  = '0;
    for (int i = Capacity - 1; i >= 0; i--) begin
      if (cell_is_free(state_q[i])) begin
        free_found = 1'b1;
        free_addr  = addr_t'(i);
      end
    end
  end

  // The address is only meaningful while some cell is free
  assign o_free_addr = free_addr;
  assign o_rsv_ready = free_found;

  ////////////////////////////////////////////////////////////////////////////
  // Cell state update
  ////////////////////////////////////////////////////////////////////////////

  // The three events always hit different cells, since a reservation takes a
  // free cell, a fill takes a reserved one and an output takes a filled one
  always_comb begin
    for (int i = 0; i < Capacity; i++) begin
      state_d[i] = state_q[i];
      if ((i_rsv_fire && free_addr == addr_t'(i)) ||
          (i_fill_fire && i_fill_addr == addr_t'(i)) ||
          (i_out_fire && i_out_addr == addr_t'(i))) begin
        state_d[i] = cell_next_state(state_q[i]);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= '{default: CELL_FREE};
    end else begin
      state_q <= state_d;
    end
  end

  // The cell leaving at the output handshake is reported in that same cycle
  always_comb begin
    o_released_onehot = '0;
    for (int i = 0; i < Capacity; i++) begin
      o_released_onehot[i] = i_out_fire && (i_out_addr == addr_t'(i));
    end
  end

endmodule

`default_nettype wire

/* common/resp_bank_cell_pkg.sv */
`default_nettype none

package resp_bank_cell_pkg;

  // Life of a cell: free, then reserved for an identifier, then holding a response
  typedef enum logic [1:0] {
    CELL_FREE     = 2'd0,
    CELL_RESERVED = 2'd1,
    CELL_FILLED   = 2'd2
  } cell_state_e;

  function automatic logic cell_is_free(cell_state_e state);
    return state == CELL_FREE;
  endfunction

  // A cell only ever moves forward around the cycle free, reserved, filled
  function automatic cell_state_e cell_next_state(cell_state_e state);
    case (state)
      CELL_FREE:     return CELL_RESERVED;
      CELL_RESERVED: return CELL_FILLED;
      default:       return CELL_FREE;
    endcase
  endfunction

endpackage

`default_nettype wire

/* common/resp_bank_cfg_pkg.sv */
`default_nettype none

package resp_bank_cfg_pkg;

  // One linked list per AXI identifier
  localparam int unsigned NumIds = 4;
  localparam int unsigned IdWidth = 2;

  // All lists share this many cells
  localparam int unsigned Capacity = 8;
  localparam int unsigned AddrWidth = 3;

  // Response bits above the identifier, the only part kept in memory
  localparam int unsigned PayloadWidth = 8;

  typedef logic [IdWidth-1:0] id_t;
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [PayloadWidth-1:0] payload_t;

  // One bit per cell, for release enables and the freed-cell report
  typedef logic [Capacity-1:0] cell_mask_t;

  // One bit per identifier
  typedef logic [NumIds-1:0] id_mask_t;

  // Needs one extra bit so that a full list of Capacity cells fits
  typedef logic [AddrWidth:0] len_t;

endpackage

`default_nettype wire
